// File: sim.f
eccPkg.sv
eccStageIf.sv
syndromeGen.sv
syndromeDecode.sv
errorCorrect.sv
eccTop.sv
tbEcc.sv

// File: run.sh
#!/bin/sh
# Build and run the ECC codec testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbEcc -f sim.f -o simEcc

out=$(./obj_dir/simEcc 2>&1) || true
echo "$out"

echo "$out" | grep -q "All checks passed"

// File: tbEcc.sv
`timescale 1ns/1ps

module tbEcc import eccPkg::*; ();

   localparam int          ResetCycles   = 8;
   localparam int          TimeoutCycles = 50;
   localparam int          StreamCount   = 200;
   localparam int          DirectedCount = 20;
   localparam int          DoubleCount   = 30;
   localparam int unsigned Seed          = 82569;
   localparam int          Latency       = 2;
   localparam int          CodeWidth     = DataWidth + CheckWidth;

   // One expected output item
   typedef struct packed {
      dataT        data;
      checkT       check;
      logic        parLo;
      logic        parHi;
      logic        uncorr;
      logic [31:0] cycle;   // Cycle the item was driven
   } expT;

   logic  clk;
   logic  rst;
   logic  validIn;
   logic  encodeIn;
   dataT  dataIn;
   checkT checkIn;
   logic  validOut;
   dataT  dataOut;
   checkT checkOut;
   logic  parityLo;
   logic  parityHi;
   logic  uncorrErr;

   expT         expQ[$];
   logic [31:0] cycleCnt;

   eccTop eccTop_inst (
      .clk_i       (clk),
      .rst_i       (rst),
      .valid_i     (validIn),
      .encode_i    (encodeIn),
      .data_i      (dataIn),
      .check_i     (checkIn),
      .valid_o     (validOut),
      .data_o      (dataOut),
      .checkOut_o  (checkOut),
      .parityLo_o  (parityLo),
      .parityHi_o  (parityHi),
      .uncorrErr_o (uncorrErr)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   always @(posedge clk) begin
      cycleCnt <= cycleCnt + 32'd1;
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic checkData(input string name, input dataT expV, input dataT actV);
      if (actV !== expV) begin
         failRun($sformatf("error %s expected 0x%h actual 0x%h", name, expV, actV));
      end
   endtask

   task automatic checkCheck(input string name, input checkT expV, input checkT actV);
      if (actV !== expV) begin
         failRun($sformatf("error %s expected 0x%h actual 0x%h", name, expV, actV));
      end
   endtask

   task automatic checkBit(input string name, input logic expV, input logic actV);
      if (actV !== expV) begin
         failRun($sformatf("error %s expected 0x%h actual 0x%h", name, expV, actV));
      end
   endtask

   // Expected outputs worked out from the SEC-DED rules
   function automatic expT refEcc(input logic enc, input dataT d, input checkT chk);
      expT         e;
      checkT       gen;
      checkT       syn;
      int unsigned weight;
      int          hitIdx;
      gen = '0;
      for (int i = 0; i < DataWidth; i++) begin
         if (d[i]) begin
            gen = gen ^ HColumns[i];
         end
      end
      syn = enc ? gen : (gen ^ chk);   // Check input ignored when encoding
      e.check  = syn;
      e.data   = d;
      e.uncorr = 1'b0;
      e.cycle  = '0;
      if (!enc) begin
         hitIdx = -1;
         weight = 0;
         for (int i = 0; i < DataWidth; i++) begin
            if (syn == HColumns[i]) begin
               hitIdx = i;
            end
         end
         for (int k = 0; k < CheckWidth; k++) begin
            if (syn[k]) begin
               weight++;
            end
         end
         if (hitIdx >= 0) begin
            e.data[hitIdx] = ~e.data[hitIdx];   // Single data bit error
         end else if (syn != '0 && weight != 1) begin
            e.uncorr = 1'b1;
         end
      end
      e.parLo = ^e.data[ByteWidth-1:0];
      e.parHi = ^e.data[DataWidth-1:ByteWidth];
      return e;
   endfunction

   function automatic checkT codeCheck(input dataT d);
      expT e;
      e = refEcc(1'b1, d, '0);
      return e.check;
   endfunction

   // Position counts data bits first, then check bits
   task automatic flipCode(inout dataT d, inout checkT c, input int pos);
      if (pos < DataWidth) begin
         d[pos] = ~d[pos];
      end else begin
         c[pos-DataWidth] = ~c[pos-DataWidth];
      end
   endtask

   task automatic driveItem(input logic enc, input dataT d, input checkT chk);
      expT e;
      e       = refEcc(enc, d, chk);
      e.cycle = cycleCnt;
      expQ.push_back(e);
      validIn  = 1'b1;
      encodeIn = enc;
      dataIn   = d;
      checkIn  = chk;
      @(posedge clk);
      #1;
   endtask

   task automatic idleCycles(input int n);
      validIn = 1'b0;
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Let every queued item come out
   task automatic waitDrain(input string phase);
      int n;
      n = 0;
      validIn = 1'b0;
      while (expQ.size() != 0) begin
         if (n == TimeoutCycles) begin
            failRun($sformatf("timeout: outputs of the %s items did not arrive", phase));
         end
         @(posedge clk);
         #1;
         n++;
      end
   endtask

   task automatic compareOutputs();
      expT e;
      if (rst) begin
         if (cycleCnt > 0) begin
            checkBit("valid_o", 1'b0, validOut);
            checkBit("uncorrErr_o", 1'b0, uncorrErr);
         end
      end else if (!validOut) begin
         checkBit("uncorrErr_o", 1'b0, uncorrErr);
         if (expQ.size() != 0 && cycleCnt >= expQ[0].cycle + Latency) begin
            failRun("an item did not appear two cycles after it was driven");
         end
      end else if (expQ.size() == 0) begin
         failRun("valid_o went high with no item in flight");
      end else begin
         e = expQ.pop_front();
         if (cycleCnt - e.cycle != Latency) begin
            failRun($sformatf("an item appeared after %0d cycles instead of two",
                              cycleCnt - e.cycle));
         end
         checkData("data_o", e.data, dataOut);
         checkCheck("checkOut_o", e.check, checkOut);
         checkBit("parityLo_o", e.parLo, parityLo);
         checkBit("parityHi_o", e.parHi, parityHi);
         checkBit("uncorrErr_o", e.uncorr, uncorrErr);
      end
   endtask

   // Outputs are settled at the falling edge
   always @(negedge clk) begin
      compareOutputs();
   end

   task automatic streamItem();
      logic  enc;
      dataT  d;
      checkT c;
      int    nErr;
      int    p1;
      int    p2;
      enc  = ($urandom_range(1, 0) == 1);
      d    = dataT'($urandom);
      nErr = int'($urandom_range(2, 0));
      if (enc) begin
         c = checkT'($urandom);   // Must be ignored
      end else begin
         c = codeCheck(d);
         p1 = int'($urandom_range(CodeWidth - 1, 0));
         p2 = int'($urandom_range(CodeWidth - 2, 0));
         if (p2 >= p1) begin
            p2++;
         end
         if (nErr > 0) begin
            flipCode(d, c, p1);
         end
         if (nErr > 1) begin
            flipCode(d, c, p2);
         end
      end
      driveItem(enc, d, c);
   endtask

   initial begin
      dataT  d;
      checkT c;
      expT   e;
      int    p1;
      int    p2;
      void'($urandom(Seed));
      rst      = 1'b1;
      validIn  = 1'b0;
      encodeIn = 1'b0;
      dataIn   = '0;
      checkIn  = '0;
      cycleCnt = '0;
      repeat (ResetCycles) @(posedge clk);
      #1;
      rst = 1'b0;
      idleCycles(4);   // Outputs stay quiet before the first item

      // Encode mode with junk on the check input
      for (int n = 0; n < DirectedCount; n++) begin
         driveItem(1'b1, dataT'($urandom), checkT'($urandom));
      end
      waitDrain("encode");

      // Clean codewords
      for (int n = 0; n < DirectedCount; n++) begin
         d = dataT'($urandom);
         driveItem(1'b0, d, codeCheck(d));
      end
      waitDrain("clean codeword");

      // Each data bit flipped once
      for (int i = 0; i < DataWidth; i++) begin
         d = dataT'($urandom);
         c = codeCheck(d);
         e = refEcc(1'b0, d ^ (dataT'(1) << i), c);
         checkCheck("reference syndrome", HColumns[i], e.check);
         checkData("reference corrected data", d, e.data);
         driveItem(1'b0, d ^ (dataT'(1) << i), c);
      end
      // Each check bit flipped once
      for (int k = 0; k < CheckWidth; k++) begin
         d = dataT'($urandom);
         c = codeCheck(d);
         driveItem(1'b0, d, c ^ (checkT'(1) << k));
      end
      waitDrain("single error");

      // Two distinct flips across the 22-bit codeword
      for (int n = 0; n < DoubleCount; n++) begin
         d  = dataT'($urandom);
         c  = codeCheck(d);
         p1 = int'($urandom_range(CodeWidth - 1, 0));
         p2 = int'($urandom_range(CodeWidth - 2, 0));
         if (p2 >= p1) begin
            p2++;
         end
         flipCode(d, c, p1);
         flipCode(d, c, p2);
         e = refEcc(1'b0, d, c);
         checkBit("reference uncorrErr", 1'b1, e.uncorr);
         driveItem(1'b0, d, c);
      end
      waitDrain("double error");

      for (int n = 0; n < StreamCount; n++) begin
         streamItem();
      end
      waitDrain("streaming");
      idleCycles(2);

      $display("All checks passed");
      $finish;
   end

endmodule

// File: eccTop.sv
`timescale 1ns/1ps

module eccTop import eccPkg::*; (
   input  logic  clk_i,
   input  logic  rst_i,
   input  logic  valid_i,
   input  logic  encode_i,
   input  dataT  data_i,
   input  checkT check_i,
   output logic  valid_o,
   output dataT  data_o,
   output checkT checkOut_o,
   output logic  parityLo_o,
   output logic  parityHi_o,
   output logic  uncorrErr_o
);

   // Carries one item between the two stages
   eccStageIf stageIf_inst ();

   // Stage 1, parity trees
   syndromeGen syndromeGen_inst (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .valid_i  (valid_i),
      .encode_i (encode_i),
      .data_i   (data_i),
      .check_i  (check_i),
      .stage_o  (stageIf_inst.src)
   );

   // Stage 2, decode and correct
   errorCorrect errorCorrect_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .stage_i     (stageIf_inst.dst),
      .valid_o     (valid_o),
      .data_o      (data_o),
      .checkOut_o  (checkOut_o),
      .parityLo_o  (parityLo_o),
      .parityHi_o  (parityHi_o),
      .uncorrErr_o (uncorrErr_o)
   );

endmodule

// File: errorCorrect.sv
`timescale 1ns/1ps

module errorCorrect import eccPkg::*; (
   input  logic   clk_i,
   input  logic   rst_i,
   eccStageIf.dst stage_i,
   output logic   valid_o,
   output dataT   data_o,
   output checkT  checkOut_o,
   output logic   parityLo_o,
   output logic   parityHi_o,
   output logic   uncorrErr_o
);

   dataT     flipMask;
   errClassE errClass;
   logic     flipLo;       // Flip falls in low byte
   logic     flipHi;       // Flip falls in high byte
   dataT     dataNext;
   logic     parLoNext;
   logic     parHiNext;
   logic     uncorrNext;

   syndromeDecode syndromeDecode_inst (
      .syndrome_i (stage_i.syndrome),
      .flipMask_o (flipMask),
      .errClass_o (errClass)
   );

   assign flipLo = |flipMask[ByteWidth-1:0];
   assign flipHi = |flipMask[DataWidth-1:ByteWidth];

   always_comb begin
      if (stage_i.encode) begin
         dataNext   = stage_i.data;   // Pass through
         parLoNext  = stage_i.parityLo;
         parHiNext  = stage_i.parityHi;
         uncorrNext = 1'b0;
      end else begin
         dataNext   = stage_i.data ^ flipMask;
         parLoNext  = stage_i.parityLo ^ flipLo;   // One flipped bit toggles parity
         parHiNext  = stage_i.parityHi ^ flipHi;
         uncorrNext = (errClass == ErrUncorr);
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_o     <= 1'b0;
         uncorrErr_o <= 1'b0;
      end else begin
         valid_o     <= stage_i.valid;
         uncorrErr_o <= stage_i.valid & uncorrNext;   // Flag only with an item
      end
   end

   always_ff @(posedge clk_i) begin
      if (stage_i.valid) begin
         data_o     <= dataNext;
         checkOut_o <= stage_i.syndrome;   // Check bits or syndrome
         parityLo_o <= parLoNext;
         parityHi_o <= parHiNext;
      end
   end

   // Unknown bits here would spread into the flag and the corrected word
   aStageKnown: assert property (
      @(posedge clk_i) disable iff (rst_i)
      stage_i.valid |-> !$isunknown({stage_i.data, stage_i.syndrome})
   ) else $error("unknown data or syndrome on a valid stage item");

endmodule

// File: syndromeDecode.sv
`timescale 1ns/1ps

module syndromeDecode import eccPkg::*; (
   input  checkT    syndrome_i,
   output dataT     flipMask_o,
   output errClassE errClass_o
);

   logic dataHit;   // Syndrome names a data bit
   logic zeroSyn;
   logic checkHit;  // Syndrome names a check bit

   // Column compare, distinct columns keep the mask one-hot
   always_comb begin
      flipMask_o = '0;
      for (int i = 0; i < DataWidth; i++) begin
         flipMask_o[i] = (syndrome_i == HColumns[i]);
      end
      assert ($onehot0(flipMask_o))
         else $error("flip mask has more than one bit set");
   end

   assign dataHit  = |flipMask_o;
   assign zeroSyn  = (syndrome_i == '0);
   assign checkHit = (checkWeight(syndrome_i) == 1);

   // Even weight nonzero syndromes land in ErrUncorr
   always_comb begin
      if (zeroSyn) begin
         errClass_o = ErrNone;
      end else if (dataHit) begin
         errClass_o = ErrData;
      end else if (checkHit) begin
         errClass_o = ErrCheck;
      end else begin
         errClass_o = ErrUncorr;
      end
   end

endmodule

// File: syndromeGen.sv
`timescale 1ns/1ps

module syndromeGen import eccPkg::*; (
   input  logic   clk_i,
   input  logic   rst_i,
   input  logic   valid_i,
   input  logic   encode_i,
   input  dataT   data_i,
   input  checkT  check_i,
   eccStageIf.src stage_o
);

   checkT genCheck;   // Check bits of the data word
   checkT checkIn;    // Received check bits, masked in encode mode
   checkT syndrome;
   logic  parLo;
   logic  parHi;

   // One XOR tree per check bit
   for (genvar c = 0; c < CheckWidth; c++) begin : gTree
      assign genCheck[c] = ^(data_i & colMask(c));
   end

   assign checkIn  = encode_i ? '0 : check_i;
   assign syndrome = genCheck ^ checkIn;   // Equals genCheck when encoding

   // Raw byte parities, corrected later
   assign parLo = bytePar(data_i[ByteWidth-1:0]);
   assign parHi = bytePar(data_i[DataWidth-1:ByteWidth]);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         stage_o.valid <= 1'b0;
      end else begin
         stage_o.valid <= valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (valid_i) begin   // Hold payload between items
         stage_o.encode   <= encode_i;
         stage_o.data     <= data_i;
         stage_o.syndrome <= syndrome;
         stage_o.parityLo <= parLo;
         stage_o.parityHi <= parHi;
      end
   end

   // The mode select decides the whole downstream path of the item
   aEncodeKnown: assert property (
      @(posedge clk_i) disable iff (rst_i)
      valid_i |-> !$isunknown(encode_i)
   ) else $error("encode_i is unknown on a valid input");

endmodule

// File: eccStageIf.sv
`timescale 1ns/1ps

interface eccStageIf import eccPkg::*; ();

   logic  valid;      // Item present this cycle
   logic  encode;     // Encode item, no correction
   dataT  data;       // Registered input word
   checkT syndrome;   // Generated check bits in encode mode
   logic  parityLo;   // Parity of raw low byte
   logic  parityHi;   // Parity of raw high byte

   modport src (
      output valid,
      output encode,
      output data,
      output syndrome,
      output parityLo,
      output parityHi
   );

   modport dst (
      input valid,
      input encode,
      input data,
      input syndrome,
      input parityLo,
      input parityHi
   );

endinterface

// File: eccPkg.sv
package eccPkg;

   localparam int DataWidth  = 16;
   localparam int CheckWidth = 6;
   localparam int ByteWidth  = 8;

   typedef logic [DataWidth-1:0]  dataT;
   typedef logic [CheckWidth-1:0] checkT;

   // Hsiao code, each column weight three, each check bit covers eight data bits
   localparam checkT HColumns [DataWidth] = '{
      6'h0B,   // d0
      6'h0D,   // d1
      6'h0E,   // d2
      6'h13,   // d3
      6'h16,   // d4
      6'h19,   // d5
      6'h1A,   // d6
      6'h1C,   // d7
      6'h23,   // d8
      6'h25,   // d9
      6'h26,   // d10
      6'h29,   // d11
      6'h2C,   // d12
      6'h31,   // d13
      6'h32,   // d14
      6'h34    // d15
   };

   typedef enum logic [1:0] {
      ErrNone,    // Zero syndrome
      ErrData,    // Matches a data column
      ErrCheck,   // Single check bit flipped
      ErrUncorr   // Anything else
   } errClassE;

   // Data bits feeding the parity tree of check bit c
   function automatic dataT colMask(input int c);
      dataT m;
      for (int i = 0; i < DataWidth; i++) begin
         m[i] = HColumns[i][c];
      end
      return m;
   endfunction

   function automatic logic bytePar(input logic [ByteWidth-1:0] b);
      return ^b;   // Even parity
   endfunction

   function automatic int unsigned checkWeight(input checkT s);
      int unsigned n;
      n = 0;
      for (int k = 0; k < CheckWidth; k++) begin
         n += s[k];
      end
      return n;
   endfunction

endpackage
